// File: clkmon_pkg.sv
package clkmon_pkg;

    // Cycle counts and the gate length share one width
    typedef logic [31:0] count_t;

    // One second of a 100 MHz ps_clk
    localparam count_t DEF_GATE_CYCLES = 32'd100_000_000;

    // Upper bound on measured channels, sizes the status word
    localparam int MAX_CLOCKS = 8;

    // Gate sequencer states
    typedef enum logic [1:0] {
        GATE_IDLE = 2'd0,   // Disabled, no gates
        GATE_ARM  = 2'd1,   // First gate goes out next cycle
        GATE_RUN  = 2'd2    // Periodic gates
    } gate_state_e;

endpackage

// File: wb_map_pkg.sv
package wb_map_pkg;

    localparam int WB_ADDR_W = 4;     // Word address
    localparam int WB_DATA_W = 32;

    // Enable bit position in REG_CTRL
    localparam int CTRL_EN_BIT = 0;

    // Register map, word addresses
    typedef enum logic [WB_ADDR_W-1:0] {
        REG_CTRL   = 4'd0,    // Bit 0 enable
        REG_STATUS = 4'd1,    // Per-channel valid bits, read only
        REG_GATE   = 4'd2,    // Gate length in ps_clk cycles
        REG_COUNT0 = 4'd4     // Channel n count at REG_COUNT0 + n, read only
    } reg_addr_e;

endpackage

// File: flag_sync.sv
module flag_sync (
    input  logic clk_a_i,
    input  logic flag_a_i,
    input  logic clk_b_i,
    output logic flag_b_o
);

    // Toggle in domain A, synchronizer and edge detect in domain B
    logic       toggle_a = 1'b0;
    logic [2:0] sync_b   = 3'b000;

    always_ff @(posedge clk_a_i) begin
        if (flag_a_i) begin
            toggle_a <= ~toggle_a;
        end
    end

    // Two synchronizer stages plus a third for edge detect
    always_ff @(posedge clk_b_i) begin
        sync_b <= {sync_b[1:0], toggle_a};
    end

    assign flag_b_o = sync_b[2] ^ sync_b[1];   // One pulse per toggle

endmodule

// File: clk_freq_counter.sv
module clk_freq_counter (
    input  logic               ps_clk,
    input  logic               rst_i,
    input  logic               meas_clk_i,
    input  logic               gate_i,
    output logic               done_o,
    output clkmon_pkg::count_t count_o
);
    import clkmon_pkg::*;

    logic   gate_meas;             // Gate pulse in the measured domain
    logic   capture_ps;            // Capture flag back in ps_clk
    count_t run_cnt  = '0;
    count_t hold_cnt = '0;

    flag_sync u_gate_sync (
        .clk_a_i  (ps_clk),
        .flag_a_i (gate_i),
        .clk_b_i  (meas_clk_i),
        .flag_b_o (gate_meas)
    );

    // Same pulse that latched hold_cnt goes back as the done flag
    flag_sync u_done_sync (
        .clk_a_i  (meas_clk_i),
        .flag_a_i (gate_meas),
        .clk_b_i  (ps_clk),
        .flag_b_o (capture_ps)
    );

    // Measured domain, free running between gates
    always_ff @(posedge meas_clk_i) begin
        if (gate_meas) begin
            hold_cnt <= run_cnt;
            run_cnt  <= '0;
        end else begin
            run_cnt <= run_cnt + 32'd1;
        end
    end

    // hold_cnt is quiet for the whole trip of the flag back to ps_clk
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            done_o  <= 1'b0;
            count_o <= '0;
        end else begin
            done_o <= capture_ps;
            if (capture_ps) begin
                count_o <= hold_cnt;
            end
        end
    end

endmodule

// File: gate_ctrl.sv
module gate_ctrl #(
    parameter int NUM_CLOCKS = 2
) (
    input  logic                  ps_clk,
    input  logic                  rst_i,
    input  logic                  enable_i,
    input  clkmon_pkg::count_t    gate_len_i,
    input  logic [NUM_CLOCKS-1:0] done_i,
    output logic                  gate_o,
    output logic [NUM_CLOCKS-1:0] valid_o
);
    import clkmon_pkg::*;

    gate_state_e           state;
    count_t                period_cnt;   // Cycles left to the next gate
    logic [NUM_CLOCKS-1:0] first_seen;   // First done after enable

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state      <= GATE_IDLE;
            period_cnt <= '0;
            gate_o     <= 1'b0;
        end else begin
            gate_o <= 1'b0;
            case (state)
                GATE_IDLE: begin
                    if (enable_i) begin
                        state <= GATE_ARM;
                    end
                end
                GATE_ARM: begin
                    if (!enable_i) begin
                        state <= GATE_IDLE;
                    end else begin
                        gate_o     <= 1'b1;
                        period_cnt <= gate_len_i - 32'd1;
                        state      <= GATE_RUN;
                    end
                end
                GATE_RUN: begin
                    if (!enable_i) begin
                        state <= GATE_IDLE;
                    end else if (period_cnt == '0) begin
                        // Reload here picks up a new gate length
                        gate_o     <= 1'b1;
                        period_cnt <= gate_len_i - 32'd1;
                    end else begin
                        period_cnt <= period_cnt - 32'd1;
                    end
                end
                default: state <= GATE_IDLE;
            endcase
        end
    end

    // The first interval after enable is partial, so valid waits for the second done
    always_ff @(posedge ps_clk) begin
        if (rst_i || !enable_i) begin
            first_seen <= '0;
            valid_o    <= '0;
        end else begin
            first_seen <= first_seen | done_i;
            valid_o    <= valid_o | (done_i & first_seen);
        end
    end

endmodule

// File: wb_regs.sv
module wb_regs #(
    parameter int                 NUM_CLOCKS  = 2,
    parameter clkmon_pkg::count_t GATE_CYCLES = clkmon_pkg::DEF_GATE_CYCLES
) (
    input  logic                                    ps_clk,
    input  logic                                    rst_i,
    input  logic                                    wb_cyc_i,
    input  logic                                    wb_stb_i,
    input  logic                                    wb_we_i,
    input  logic [wb_map_pkg::WB_ADDR_W-1:0]        wb_adr_i,
    input  logic [wb_map_pkg::WB_DATA_W-1:0]        wb_dat_i,
    input  logic [NUM_CLOCKS-1:0]                   valid_i,
    input  clkmon_pkg::count_t [NUM_CLOCKS-1:0]     counts_i,
    output logic [wb_map_pkg::WB_DATA_W-1:0]        wb_dat_o,
    output logic                                    wb_ack_o,
    output logic                                    enable_o,
    output clkmon_pkg::count_t                      gate_len_o
);
    import clkmon_pkg::*;
    import wb_map_pkg::*;

    logic                 req;
    logic                 req_d;        // Request seen last cycle
    logic                 new_req;
    logic [MAX_CLOCKS-1:0] status;
    logic [WB_DATA_W-1:0] rd_data;

    assign req     = wb_cyc_i & wb_stb_i;
    assign new_req = req & ~req_d;      // One ack per strobe

    always_comb begin
        status = '0;
        status[NUM_CLOCKS-1:0] = valid_i;
    end

    // Read mux, unmapped addresses read zero
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            REG_CTRL:   rd_data[CTRL_EN_BIT] = enable_o;
            REG_STATUS: rd_data[MAX_CLOCKS-1:0] = status;
            REG_GATE:   rd_data = gate_len_o;
            default: begin
                for (int n = 0; n < NUM_CLOCKS; n++) begin
                    if (wb_adr_i == WB_ADDR_W'(REG_COUNT0 + n)) begin
                        rd_data = counts_i[n];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            req_d    <= 1'b0;
            wb_ack_o <= 1'b0;
        end else begin
            req_d    <= req;
            wb_ack_o <= new_req;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (new_req) begin
            wb_dat_o <= rd_data;
        end
    end

    // Writes land on the edge that raises ack
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            enable_o   <= 1'b0;
            gate_len_o <= GATE_CYCLES;
        end else if (new_req && wb_we_i) begin
            case (wb_adr_i)
                REG_CTRL: enable_o <= wb_dat_i[CTRL_EN_BIT];
                REG_GATE: begin
                    // Zero length would stall the gate counter
                    gate_len_o <= (wb_dat_i == '0) ? 32'd1 : wb_dat_i;
                end
                default: ;                 // Read only or unmapped
            endcase
        end
    end

endmodule

// File: clkmon_top.sv
module clkmon_top #(
    parameter int                 NUM_CLOCKS  = 2,
    parameter clkmon_pkg::count_t GATE_CYCLES = clkmon_pkg::DEF_GATE_CYCLES
) (
    input  logic                             ps_clk,
    input  logic                             rst_i,
    input  logic [NUM_CLOCKS-1:0]            meas_clk_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [wb_map_pkg::WB_ADDR_W-1:0] wb_adr_i,
    input  logic [wb_map_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [wb_map_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                             wb_ack_o
);
    import clkmon_pkg::*;

    logic                      enable;
    count_t                    gate_len;
    logic                      gate_pulse;
    logic [NUM_CLOCKS-1:0]     done;
    logic [NUM_CLOCKS-1:0]     valid;
    count_t [NUM_CLOCKS-1:0]   counts;

    gate_ctrl #(
        .NUM_CLOCKS (NUM_CLOCKS)
    ) u_gate_ctrl (
        .ps_clk     (ps_clk),
        .rst_i      (rst_i),
        .enable_i   (enable),
        .gate_len_i (gate_len),
        .done_i     (done),
        .gate_o     (gate_pulse),
        .valid_o    (valid)
    );

    // One counter per measured clock, all on the same gate
    for (genvar i = 0; i < NUM_CLOCKS; i++) begin : g_counter
        clk_freq_counter u_counter (
            .ps_clk     (ps_clk),
            .rst_i      (rst_i),
            .meas_clk_i (meas_clk_i[i]),
            .gate_i     (gate_pulse),
            .done_o     (done[i]),
            .count_o    (counts[i])
        );
    end

    wb_regs #(
        .NUM_CLOCKS  (NUM_CLOCKS),
        .GATE_CYCLES (GATE_CYCLES)
    ) u_wb_regs (
        .ps_clk     (ps_clk),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .valid_i    (valid),
        .counts_i   (counts),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .enable_o   (enable),
        .gate_len_o (gate_len)
    );

endmodule

// File: clkmon_tb.sv
module clkmon_tb;
    import clkmon_pkg::*;
    import wb_map_pkg::*;

    localparam int     NUM_CLOCKS    = 2;
    localparam count_t GATE_RESET    = 32'd200;
    localparam int     PS_PERIOD     = 20;
    localparam int     MEAS_PERIOD_A = 14;
    localparam int     MEAS_PERIOD_B = 46;
    localparam int     ACK_LIMIT     = 16;     // Cycles allowed for wb_ack_o

    logic                 ps_clk;
    logic                 rst;
    logic                 meas_clk_a;
    logic                 meas_clk_b;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_wdat;
    logic [WB_DATA_W-1:0] wb_rdat;
    logic                 wb_ack;

    logic [31:0] cycle_cnt;
    logic [31:0] rng_state;
    int          checks       = 0;
    int          value_errs   = 0;
    int          timeout_errs = 0;
    int          bus_errs     = 0;

    clkmon_top #(
        .NUM_CLOCKS  (NUM_CLOCKS),
        .GATE_CYCLES (GATE_RESET)
    ) dut0 (
        .ps_clk     (ps_clk),
        .rst_i      (rst),
        .meas_clk_i ({meas_clk_b, meas_clk_a}),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_we_i    (wb_we),
        .wb_adr_i   (wb_adr),
        .wb_dat_i   (wb_wdat),
        .wb_dat_o   (wb_rdat),
        .wb_ack_o   (wb_ack)
    );

    initial begin
        ps_clk = 1'b0;
        forever #(PS_PERIOD / 2) ps_clk = ~ps_clk;
    end

    initial begin
        meas_clk_a = 1'b0;
        forever #(MEAS_PERIOD_A / 2) meas_clk_a = ~meas_clk_a;
    end

    initial begin
        meas_clk_b = 1'b0;
        forever #(MEAS_PERIOD_B / 2) meas_clk_b = ~meas_clk_b;
    end

    always @(posedge ps_clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    // Ack exactly one cycle after a new request, and only for one cycle
    ack_after_req: assert property (@(posedge ps_clk) disable iff (rst)
        $rose(wb_cyc && wb_stb) |=> wb_ack)
        else begin
            bus_errs++;
            $display("wb_ack_o did not follow a new request by one cycle");
        end

    ack_one_cycle: assert property (@(posedge ps_clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            bus_errs++;
            $display("wb_ack_o stayed high for more than one cycle");
        end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic bus_cycle(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] wdat,
                             output logic [WB_DATA_W-1:0] rdat);
        int waits;
        waits = 0;
        @(posedge ps_clk);
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        wb_we   <= we;
        wb_adr  <= adr;
        wb_wdat <= wdat;
        do begin
            @(posedge ps_clk);
            waits++;
        end while (!wb_ack && waits < ACK_LIMIT);
        rdat = wb_rdat;                         // Valid together with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        assert (wb_ack) else begin
            timeout_errs++;
            $display("No ack within %0d cycles at address %0d", ACK_LIMIT, adr);
        end
    endtask

    task automatic reg_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
        logic [WB_DATA_W-1:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic reg_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            value_errs++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_near(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        logic [31:0] diff;
        diff = (got > exp) ? got - exp : exp - got;
        checks++;
        assert (diff <= 32'd2) else begin
            value_errs++;
            $display("FAILED %s got %h expected %h +-2", name, got, exp);
        end
    endtask

    // Ideal count is the gate time over the measured period
    task automatic check_counts(input logic [31:0] g);
        logic [31:0] got;
        reg_read(WB_ADDR_W'(REG_COUNT0), got);
        expect_near("count0", got, (g * PS_PERIOD) / MEAS_PERIOD_A);
        reg_read(WB_ADDR_W'(REG_COUNT0 + 1), got);
        expect_near("count1", got, (g * PS_PERIOD) / MEAS_PERIOD_B);
    endtask

    task automatic wait_valid(input logic [31:0] g, input logic [31:0] start);
        logic [31:0] status;
        status = '0;
        while (status[1:0] != 2'b11 && (cycle_cnt - start) <= (32'd2 * g + 32'd8)) begin
            reg_read(REG_STATUS, status);
        end
        checks++;
        assert (status[1:0] == 2'b11) else begin
            timeout_errs++;
            $display("Valid bits not set within %0d cycles of enable", 2 * g + 8);
        end
    endtask

    initial begin
        logic [31:0] rdat;
        logic [31:0] g;
        logic [31:0] prev_g;
        logic [31:0] start;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_wdat   = '0;
        rng_state = 32'h1591_1328;
        repeat (5) @(posedge ps_clk);
        rst <= 1'b0;

        reg_read(REG_CTRL, rdat);
        expect_equal("ctrl", rdat, 32'd0);
        reg_read(REG_STATUS, rdat);
        expect_equal("status", rdat, 32'd0);
        reg_read(REG_GATE, rdat);
        expect_equal("gate_len", rdat, GATE_RESET);
        for (int n = 0; n < NUM_CLOCKS; n++) begin
            reg_read(WB_ADDR_W'(REG_COUNT0 + n), rdat);
            expect_equal($sformatf("count%0d", n), rdat, 32'd0);
        end
        reg_read(4'd3, rdat);                   // Unmapped
        expect_equal("unmapped3", rdat, 32'd0);
        reg_read(4'd15, rdat);
        expect_equal("unmapped15", rdat, 32'd0);

        start = cycle_cnt;
        reg_write(REG_CTRL, 32'd1);
        reg_read(REG_CTRL, rdat);
        expect_equal("ctrl", rdat, 32'd1);
        wait_valid(GATE_RESET, start);
        check_counts(GATE_RESET);

        // New lengths take effect at the next gate while running
        g = GATE_RESET;
        for (int i = 0; i < 3; i++) begin
            prev_g    = g;
            rng_state = lcg_next(rng_state);
            g         = 32'd100 + ((rng_state >> 8) % 32'd301);
            reg_write(REG_GATE, g);
            reg_read(REG_GATE, rdat);
            expect_equal("gate_len", rdat, g);
            repeat (prev_g + 32'd2 * g + 32'd16) @(posedge ps_clk);
            check_counts(g);
        end
        reg_read(REG_STATUS, rdat);
        expect_equal("status", rdat, 32'd3);

        reg_write(REG_CTRL, 32'd0);
        reg_read(REG_STATUS, rdat);
        expect_equal("status", rdat, 32'd0);
        repeat (40) @(posedge ps_clk);          // Last done pulses drain

        reg_write(REG_STATUS, 32'hFFFF_FFFF);
        reg_read(REG_STATUS, rdat);
        expect_equal("status", rdat, 32'd0);
        for (int n = 0; n < NUM_CLOCKS; n++) begin
            reg_write(WB_ADDR_W'(REG_COUNT0 + n), 32'h5A5A_0000 + 32'(n));
        end
        check_counts(g);                        // Still the last measurement

        reg_write(REG_GATE, 32'd0);
        reg_read(REG_GATE, rdat);
        expect_equal("gate_len", rdat, 32'd1);   // Zero stored as one

        reg_write(REG_GATE, GATE_RESET);
        start = cycle_cnt;
        reg_write(REG_CTRL, 32'd1);
        wait_valid(GATE_RESET, start);
        check_counts(GATE_RESET);

        $display("Checks %0d, value errors %0d, timeouts %0d, bus errors %0d",
                 checks, value_errs, timeout_errs, bus_errs);
        if (value_errs == 0 && timeout_errs == 0 && bus_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
clkmon_pkg.sv
wb_map_pkg.sv
flag_sync.sv
clk_freq_counter.sv
gate_ctrl.sv
wb_regs.sv
clkmon_top.sv
clkmon_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run clkmon_tb with Verilator

cd "$(dirname "$0")" || exit 1

top=clkmon_tb
build_dir=obj_dir
log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module "$top" \
    -Mdir "$build_dir" \
    -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# Verdict from the log
if grep -q "sim failed" "$log"; then
    exit 1
fi
exit 0
